// File: build.f
raster_pkg.sv
pipe.sv
frame_buffer.sv
triangle_controller.sv
edge_setup.sv
triangle_fill.sv
raster_top.sv
raster_tb.sv

// File: edge_setup.sv
module edge_setup (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  input  logic                  tri_valid,
  input  raster_pkg::triangle_t tri_data,
  output logic                  setup_valid,
  output raster_pkg::edge_t     edge_a [3],
  output raster_pkg::edge_t     edge_b [3],
  output raster_pkg::edge_t     edge_c [3],
  output raster_pkg::color_t    color
);

  import raster_pkg::*;

  edge_t vx [3];
  edge_t vy [3];

  always_comb begin
    vx[0] = edge_t'(tri_data.x0);
    vy[0] = edge_t'(tri_data.y0);
    vx[1] = edge_t'(tri_data.x1);
    vy[1] = edge_t'(tri_data.y1);
    vx[2] = edge_t'(tri_data.x2);
    vy[2] = edge_t'(tri_data.y2);
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      setup_valid <= 1'b0;
    end else begin
      setup_valid <= tri_valid;
    end
  end

  // edge i runs from vertex i to vertex (i+1)%3
  // e = A*x + B*y + C
  always_ff @(posedge sys_clk) begin
    if (tri_valid) begin
      for (int i = 0; i < 3; i++) begin
        edge_a[i] <= vy[(i + 1) % 3] - vy[i];
        edge_b[i] <= vx[i] - vx[(i + 1) % 3];
        edge_c[i] <= vy[i] * (vx[(i + 1) % 3] - vx[i])
                   - vx[i] * (vy[(i + 1) % 3] - vy[i]);
      end
      color <= tri_data.color;
    end
  end

endmodule

// File: frame_buffer.sv
module frame_buffer (
  input  logic                  sys_clk,
  input  logic                  wr_en,
  input  raster_pkg::pix_addr_t wr_addr,
  input  raster_pkg::color_t    wr_data,
  input  raster_pkg::pix_addr_t rd_addr,
  output raster_pkg::color_t    rd_data
);

  import raster_pkg::*;

  color_t pix_mem [FRAME_PIXELS];

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      pix_mem[wr_addr] <= wr_data;
    end
  end

  // one cycle read latency
  always_ff @(posedge sys_clk) begin
    rd_data <= pix_mem[rd_addr];
  end

  a_wr_in_frame: assert property (
    @(posedge sys_clk)
    wr_en |-> (int'(wr_addr) < FRAME_PIXELS)
  ) else $error("pixel write outside the frame");

endmodule

// File: pipe.sv
module pipe #(
  parameter type payload_t = logic,
  parameter int  length    = 1
) (
  input  logic     sys_clk,
  input  logic     sys_rst,
  input  payload_t in,
  output payload_t out
);

  payload_t stages [length];

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      for (int i = 0; i < length; i++) begin
        stages[i] <= '0;
      end
    end else begin
      stages[0] <= in;
      for (int i = 1; i < length; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign out = stages[length-1];

endmodule

// File: raster_pkg.sv
package raster_pkg;

  localparam int FRAME_WIDTH = 16;
  localparam int FRAME_HEIGHT = 12;
  localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

  localparam int MAX_TRIANGLES = 16;

  // cycles from scanned pixel to inside flag
  localparam int FILL_LATENCY = 2;

  typedef logic [4:0] coord_t;
  typedef logic [11:0] color_t;  // r4 g4 b4
  typedef logic [$clog2(FRAME_PIXELS)-1:0] pix_addr_t;
  typedef logic signed [13:0] edge_t;

  typedef logic [$clog2(MAX_TRIANGLES)-1:0] tri_addr_t;
  typedef logic [$clog2(MAX_TRIANGLES+1)-1:0] tri_count_t;

  typedef struct packed {
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    coord_t x2;
    coord_t y2;
    color_t color;
  } triangle_t;

endpackage

// File: raster_tb.sv
module raster_tb;

  import raster_pkg::*;

  // empty frame, seven one-triangle frames, one three-triangle frame
  localparam int FRAME_CYCLES = (0 * 195 + 20) + 7 * (1 * 195 + 20) + (3 * 195 + 20);
  localparam int READ_CYCLES = 6 * (2 * FRAME_PIXELS + 4);  // six full read-backs
  localparam int TIMEOUT_CYCLES = FRAME_CYCLES + READ_CYCLES + 60;

  logic       sys_clk = 1'b0;
  logic       sys_rst;
  logic       tri_wr_en;
  tri_addr_t  tri_wr_addr;
  triangle_t  tri_wr_data;
  tri_count_t tri_count;
  logic       start;
  logic       clear_mode;
  pix_addr_t  pix_rd_addr;
  logic       busy;
  logic       frame_done;
  color_t     pix_rd_data;

  color_t      model_frame [FRAME_PIXELS];
  color_t      readback [FRAME_PIXELS];
  color_t      snapshot [FRAME_PIXELS];
  logic [15:0] lfsr_state = 16'd25277;
  triangle_t   saved_tri;
  int          cycle_count = 0;

  raster_top raster_top_i (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .tri_wr_en(tri_wr_en), .tri_wr_addr(tri_wr_addr),
    .tri_wr_data(tri_wr_data), .tri_count(tri_count), .start(start),
    .clear_mode(clear_mode), .pix_rd_addr(pix_rd_addr), .busy(busy),
    .frame_done(frame_done), .pix_rd_data(pix_rd_data)
  );

  always #10 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "stopped on timeout");
    end
  end

  task automatic check(input string test_name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %h actual %h", test_name, expected, actual);
      $display("Verification failed");
      $fatal(1, "stopped on mismatch");
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic triangle_t random_triangle();
    triangle_t t;
    t.x0 = coord_t'(random_bits(4));
    t.y0 = coord_t'(random_bits(4));  // rows past 11 fall off the frame
    t.x1 = coord_t'(random_bits(4));
    t.y1 = coord_t'(random_bits(4));
    t.x2 = coord_t'(random_bits(4));
    t.y2 = coord_t'(random_bits(4));
    t.color = color_t'(random_bits(12));
    return t;
  endfunction

  function automatic int edge_value(input int xa, input int ya, input int xb, input int yb,
                                    input int x, input int y);
    return (x - xa) * (yb - ya) - (y - ya) * (xb - xa);
  endfunction

  task automatic model_clear();
    foreach (model_frame[a]) model_frame[a] = '0;
  endtask

  task automatic model_draw(input triangle_t t);
    int e0, e1, e2;
    for (int y = 0; y < FRAME_HEIGHT; y++) begin
      for (int x = 0; x < FRAME_WIDTH; x++) begin
        e0 = edge_value(t.x0, t.y0, t.x1, t.y1, x, y);
        e1 = edge_value(t.x1, t.y1, t.x2, t.y2, x, y);
        e2 = edge_value(t.x2, t.y2, t.x0, t.y0, x, y);
        if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))
          model_frame[y * FRAME_WIDTH + x] = t.color;
      end
    end
  endtask

  task automatic write_triangle(input int idx, input triangle_t t);
    @(posedge sys_clk);
    tri_wr_en   <= 1'b1;
    tri_wr_addr <= tri_addr_t'(idx);
    tri_wr_data <= t;
    @(posedge sys_clk);
    tri_wr_en <= 1'b0;
  endtask

  task automatic run_frame(input int n, input logic clear, output int done_count,
                           output logic saw_busy);
    @(posedge sys_clk);
    tri_count  <= tri_count_t'(n);
    clear_mode <= clear;
    start      <= 1'b1;
    @(posedge sys_clk);
    start <= 1'b0;
    @(negedge sys_clk);
    saw_busy   = busy;  // first cycle after start
    done_count = 0;
    while (done_count == 0) begin
      @(negedge sys_clk);
      if (frame_done) done_count++;
    end
    repeat (4) begin
      @(negedge sys_clk);
      if (frame_done) done_count++;  // must stay a single pulse
    end
    @(posedge sys_clk);
    clear_mode <= 1'b0;
  endtask

  task automatic read_frame();
    for (int a = 0; a < FRAME_PIXELS; a++) begin
      @(posedge sys_clk);
      pix_rd_addr <= pix_addr_t'(a);
      @(posedge sys_clk);
      @(negedge sys_clk);
      readback[a] = pix_rd_data;
    end
  endtask

  task automatic compare_frame(input string test_name);
    read_frame();
    for (int a = 0; a < FRAME_PIXELS; a++) check(test_name, model_frame[a], readback[a]);
  endtask

  task automatic test_reset_and_empty();
    int   done_count;
    logic saw_busy;
    @(negedge sys_clk);
    check("reset_and_empty", 0, busy);
    check("reset_and_empty", 0, frame_done);
    read_frame();
    snapshot = readback;
    run_frame(0, 1'b0, done_count, saw_busy);
    check("reset_and_empty", 1, saw_busy);
    check("reset_and_empty", 1, done_count);
    check("reset_and_empty", 0, busy);
    read_frame();
    for (int a = 0; a < FRAME_PIXELS; a++) check("reset_and_empty", snapshot[a], readback[a]);
  endtask

  task automatic test_clear_mode();
    int   done_count;
    logic saw_busy;
    write_triangle(0, random_triangle());
    run_frame(1, 1'b0, done_count, saw_busy);
    run_frame(1, 1'b1, done_count, saw_busy);
    check("clear_mode", 1, saw_busy);
    check("clear_mode", 1, done_count);
    model_clear();
    compare_frame("clear_mode");
  endtask

  task automatic test_single_triangle();
    int   done_count;
    logic saw_busy;
    saved_tri = random_triangle();
    write_triangle(0, saved_tri);
    run_frame(1, 1'b1, done_count, saw_busy);
    run_frame(1, 1'b0, done_count, saw_busy);
    check("single_triangle", 1, saw_busy);
    check("single_triangle", 1, done_count);
    model_clear();
    model_draw(saved_tri);
    compare_frame("single_triangle");
  endtask

  task automatic test_reversed_winding();
    int        done_count;
    logic      saw_busy;
    triangle_t t;
    t    = saved_tri;
    t.x0 = saved_tri.x2;
    t.y0 = saved_tri.y2;
    t.x2 = saved_tri.x0;
    t.y2 = saved_tri.y0;
    write_triangle(0, t);
    run_frame(1, 1'b1, done_count, saw_busy);
    run_frame(1, 1'b0, done_count, saw_busy);
    check("reversed_winding", 1, saw_busy);
    check("reversed_winding", 1, done_count);
    model_clear();
    model_draw(saved_tri);  // same frame as the original order
    compare_frame("reversed_winding");
  endtask

  task automatic test_overlap_three();
    int        done_count;
    logic      saw_busy;
    triangle_t tris [3];
    for (int i = 0; i < 3; i++) begin
      tris[i] = random_triangle();
      write_triangle(i, tris[i]);
    end
    run_frame(1, 1'b1, done_count, saw_busy);
    run_frame(3, 1'b0, done_count, saw_busy);
    check("overlap_three", 1, saw_busy);
    check("overlap_three", 1, done_count);
    check("overlap_three", 0, busy);
    model_clear();
    for (int i = 0; i < 3; i++) model_draw(tris[i]);
    compare_frame("overlap_three");
  endtask

  initial begin
    sys_rst     = 1'b1;
    tri_wr_en   = 1'b0;
    tri_wr_addr = '0;
    tri_wr_data = '0;
    tri_count   = '0;
    start       = 1'b0;
    clear_mode  = 1'b0;
    pix_rd_addr = '0;
    repeat (3) @(posedge sys_clk);
    sys_rst <= 1'b0;
    test_reset_and_empty();
    test_clear_mode();
    test_single_triangle();
    test_reversed_winding();
    test_overlap_three();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: raster_top.sv
module raster_top (
  input  logic                   sys_clk,
  input  logic                   sys_rst,
  input  logic                   tri_wr_en,
  input  raster_pkg::tri_addr_t  tri_wr_addr,
  input  raster_pkg::triangle_t  tri_wr_data,
  input  raster_pkg::tri_count_t tri_count,
  input  logic                   start,
  input  logic                   clear_mode,
  input  raster_pkg::pix_addr_t  pix_rd_addr,
  output logic                   busy,
  output logic                   frame_done,
  output raster_pkg::color_t     pix_rd_data
);

  import raster_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_requesting,
    st_waiting,
    st_setup,
    st_filling
  } seq_state_t;

  seq_state_t state;
  coord_t     col, row;

  logic       ctrl_busy, tri_request, tri_valid;
  triangle_t  tri_data;
  logic       setup_valid;
  edge_t      edge_a [3];
  edge_t      edge_b [3];
  edge_t      edge_c [3];
  color_t     tri_color, color_d;
  logic       scan_valid, is_inside, inside_valid;
  pix_addr_t  scan_addr, addr_d;
  logic       pix_wr_en;
  color_t     pix_wr_data;

  assign tri_request = (state == st_requesting);
  assign scan_valid  = (state == st_filling);
  assign scan_addr   = pix_addr_t'(row * FRAME_WIDTH + col);
  assign busy        = ctrl_busy || (state != st_idle);  // covers the final wait

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state      <= st_idle;
      col        <= '0;
      row        <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        st_idle: if (ctrl_busy) state <= st_requesting;
        st_requesting: state <= st_waiting;
        st_waiting: begin
          if (tri_valid) begin
            state <= st_setup;
          end else if (!ctrl_busy) begin
            state      <= st_idle;  // no triangles left
            frame_done <= 1'b1;
          end
        end
        st_setup: if (setup_valid) state <= st_filling;
        st_filling: begin
          if (col == coord_t'(FRAME_WIDTH - 1)) begin
            col <= '0;
            if (row == coord_t'(FRAME_HEIGHT - 1)) begin
              row   <= '0;
              state <= st_requesting;
            end else begin
              row <= row + 1'b1;
            end
          end else begin
            col <= col + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  triangle_controller controller_i (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .start(start), .tri_request(tri_request),
    .wr_en(tri_wr_en), .wr_addr(tri_wr_addr), .wr_data(tri_wr_data),
    .tri_count(tri_count), .busy(ctrl_busy), .tri_valid(tri_valid), .tri_data(tri_data)
  );

  edge_setup setup_i (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .tri_valid(tri_valid), .tri_data(tri_data),
    .setup_valid(setup_valid), .edge_a(edge_a), .edge_b(edge_b), .edge_c(edge_c),
    .color(tri_color)
  );

  triangle_fill fill_i (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .setup_valid(setup_valid),
    .edge_a(edge_a), .edge_b(edge_b), .edge_c(edge_c), .scan_valid(scan_valid),
    .col(col), .row(row), .is_inside(is_inside), .inside_valid(inside_valid)
  );

  // color and address kept in step with the fill pipeline
  pipe #(.payload_t(color_t), .length(FILL_LATENCY)) color_pipe_i (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .in(tri_color), .out(color_d)
  );

  pipe #(.payload_t(pix_addr_t), .length(FILL_LATENCY)) addr_pipe_i (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .in(scan_addr), .out(addr_d)
  );

  assign pix_wr_en   = inside_valid && (is_inside || clear_mode);
  assign pix_wr_data = clear_mode ? '0 : color_d;  // clear writes black

  frame_buffer fb_i (
    .sys_clk(sys_clk), .wr_en(pix_wr_en), .wr_addr(addr_d), .wr_data(pix_wr_data),
    .rd_addr(pix_rd_addr), .rd_data(pix_rd_data)
  );

endmodule

// File: triangle_controller.sv
module triangle_controller (
  input  logic                   sys_clk,
  input  logic                   sys_rst,
  input  logic                   start,
  input  logic                   tri_request,
  input  logic                   wr_en,
  input  raster_pkg::tri_addr_t  wr_addr,
  input  raster_pkg::triangle_t  wr_data,
  input  raster_pkg::tri_count_t tri_count,
  output logic                   busy,
  output logic                   tri_valid,
  output raster_pkg::triangle_t  tri_data
);

  import raster_pkg::*;

  triangle_t  tri_mem [MAX_TRIANGLES];
  tri_count_t issue_idx;  // next triangle to hand out
  logic       issue;

  assign issue = busy && tri_request && (issue_idx < tri_count);

  // host write port
  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      tri_mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      busy      <= 1'b0;
      tri_valid <= 1'b0;
      issue_idx <= '0;
    end else begin
      tri_valid <= 1'b0;
      if (start) begin
        busy      <= 1'b1;
        issue_idx <= '0;
      end else if (busy && tri_request) begin
        if (issue) begin
          tri_valid <= 1'b1;
          issue_idx <= issue_idx + 1'b1;
        end else begin
          busy <= 1'b0;  // list exhausted
        end
      end
    end
  end

  // payload register
  always_ff @(posedge sys_clk) begin
    if (issue) begin
      tri_data <= tri_mem[tri_addr_t'(issue_idx)];
    end
  end

  a_valid_while_busy: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    tri_valid |-> busy
  ) else $error("tri_valid raised outside a frame");

endmodule

// File: triangle_fill.sv
module triangle_fill (
  input  logic               sys_clk,
  input  logic               sys_rst,
  input  logic               setup_valid,
  input  raster_pkg::edge_t  edge_a [3],
  input  raster_pkg::edge_t  edge_b [3],
  input  raster_pkg::edge_t  edge_c [3],
  input  logic               scan_valid,
  input  raster_pkg::coord_t col,
  input  raster_pkg::coord_t row,
  output logic               is_inside,
  output logic               inside_valid
);

  import raster_pkg::*;

  edge_t a_q [3];
  edge_t b_q [3];
  edge_t c_q [3];
  edge_t edge_val [3];
  logic  val_valid;

  // held for the whole sweep
  always_ff @(posedge sys_clk) begin
    if (setup_valid) begin
      a_q <= edge_a;
      b_q <= edge_b;
      c_q <= edge_c;
    end
  end

  always_ff @(posedge sys_clk) begin
    for (int i = 0; i < 3; i++) begin
      edge_val[i] <= a_q[i] * edge_t'(col) + b_q[i] * edge_t'(row) + c_q[i];  // stage one
    end
    is_inside <= ((edge_val[0] >= 0) && (edge_val[1] >= 0) && (edge_val[2] >= 0))
              || ((edge_val[0] <= 0) && (edge_val[1] <= 0) && (edge_val[2] <= 0));
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      val_valid    <= 1'b0;
      inside_valid <= 1'b0;
    end else begin
      val_valid    <= scan_valid;
      inside_valid <= val_valid;
    end
  end

  a_fill_latency: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    inside_valid == $past(scan_valid, FILL_LATENCY)
  ) else $error("inside_valid out of step with scan_valid");

endmodule
